// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_misc
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== branch_unit.sv ====
/*
 * branch resolution for the misc pipe: evaluates the condition and the target
 * and flags a redirect when the resolved next pc differs from the predicted one
 */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import misc_pkg::*; (
  input  wire logic            valid_i,
  input  wire logic            signed_i,
  input  wire branch_op_e      branch_op_i,
  input  wire logic [XLEN-1:0] pc_i,
  input  wire logic [XLEN-1:0] npc_i,
  input  wire logic [XLEN-1:0] imm_i,
  input  wire logic [XLEN-1:0] src0_i,
  input  wire logic [XLEN-1:0] src1_i,
  output logic                 taken_o,
  output logic [XLEN-1:0]      target_o,
  output logic                 redirect_o
);

  logic            eq;
  logic            lt;
  logic            cond;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] actual_npc;

  // ==============================
  // condition
  // ==============================
  assign eq = (src0_i == src1_i);
  assign lt = signed_i ? ($signed(src0_i) < $signed(src1_i)) : (src0_i < src1_i);

  always_comb begin
    case (branch_op_i)
      BEQ:     cond = eq;
      BNE:     cond = ~eq;
      BLT:     cond = lt;
      BGE:     cond = ~lt;
      B:       cond = 1'b1;
      JIRL:    cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  // ==============================
  // target and redirect
  // ==============================
  // jirl is register indirect, everything else pc relative
  assign base   = (branch_op_i == JIRL) ? src0_i : pc_i;
  assign target = base + imm_i;

  assign actual_npc = cond ? target : (pc_i + XLEN'(4));

  assign taken_o    = valid_i & cond;
  assign target_o   = valid_i ? target : '0;
  assign redirect_o = valid_i & (actual_npc != npc_i);

endmodule

`default_nettype wire

// ==== csr_file.sv ====
/*
 * small CSR file with combinational read and commit-time write,
 * plus the free-running stable counter and the timer id seen by rdcnt ops
 */
`timescale 1ns/1ps
`default_nettype none

module csr_file import misc_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [CSR_ADDR_W-1:0] raddr_i,
  input  wire logic                  commit_we_i,
  input  wire logic [CSR_ADDR_W-1:0] waddr_i,
  input  wire logic [XLEN-1:0]       wdata_i,
  output logic      [XLEN-1:0]       rdata_o,
  output logic      [63:0]           timer_64_o,
  output logic      [XLEN-1:0]       timer_id_o
);

  logic [XLEN-1:0]         crmd_q;
  logic [XLEN-1:0]         prmd_q;
  logic [XLEN-1:0]         era_q;
  logic [3:0][XLEN-1:0]    save_q;
  logic [XLEN-1:0]         tid_q;
  logic [63:0]             timer_q;

  // ==============================
  // read port
  // ==============================
  // unimplemented numbers read as zero
  always_comb begin
    case (raddr_i)
      CSR_CRMD:  rdata_o = crmd_q;
      CSR_PRMD:  rdata_o = prmd_q;
      CSR_ERA:   rdata_o = era_q;
      CSR_SAVE0: rdata_o = save_q[0];
      CSR_SAVE1: rdata_o = save_q[1];
      CSR_SAVE2: rdata_o = save_q[2];
      CSR_SAVE3: rdata_o = save_q[3];
      CSR_TID:   rdata_o = tid_q;
      default:   rdata_o = '0;
    endcase
  end

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      crmd_q <= '0;
      prmd_q <= '0;
      era_q  <= '0;
      save_q <= '0;
      tid_q  <= '0;
    end else if (commit_we_i) begin
      // writes to other numbers fall through
      case (waddr_i)
        CSR_CRMD:  crmd_q    <= wdata_i;
        CSR_PRMD:  prmd_q    <= wdata_i;
        CSR_ERA:   era_q     <= wdata_i;
        CSR_SAVE0: save_q[0] <= wdata_i;
        CSR_SAVE1: save_q[1] <= wdata_i;
        CSR_SAVE2: save_q[2] <= wdata_i;
        CSR_SAVE3: save_q[3] <= wdata_i;
        CSR_TID:   tid_q     <= wdata_i;
        default: ;
      endcase
    end
  end

  // ==============================
  // stable counter
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  assign timer_64_o = timer_q;
  assign timer_id_o = tid_q;

endmodule

`default_nettype wire

// ==== flist.f ====
misc_pkg.sv
branch_unit.sv
csr_file.sv
misc_pipe.sv
misc_subsystem.sv
tb_checker.sv
tb_misc.sv

// ==== misc_pipe.sv ====
/*
 * three-stage misc execution pipe for branch, CSR and counter-read ops;
 * valid/ready between stages, global flush, CSR ops serialised behind pending writes
 */
`timescale 1ns/1ps
`default_nettype none

module misc_pipe import misc_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  flush_i,
  input  wire misc_exe_t             exe_i,
  output logic                       ready_o,
  output logic      [CSR_ADDR_W-1:0] csr_raddr_o,
  input  wire logic [XLEN-1:0]       csr_rdata_i,
  input  wire logic [63:0]           timer_64_i,
  input  wire logic [XLEN-1:0]       timer_id_i,
  output misc_wb_t                   wb_o,
  input  wire logic                  wb_ready_i
);

  logic s1_ready;
  logic s2_ready;
  logic csr_hold;

  // stage1 state
  logic            s1_valid;
  misc_exe_t       s1_exe;
  logic [XLEN-1:0] s1_csr_rdata;
  logic [63:0]     s1_timer_64;
  logic [XLEN-1:0] s1_timer_id;

  // stage1 results
  logic            s1_csr_we;
  logic [XLEN-1:0] s1_csr_wdata;
  logic [XLEN-1:0] s1_wdata;
  logic            br_taken;
  logic            br_redirect;
  logic [XLEN-1:0] br_target;
  misc_wb_t        s1_wb;

  // stage2 state
  logic            s2_valid;
  misc_wb_t        s2_rec;

  // ==============================
  // stage0
  // ==============================
  // a CSR op waits until every older CSR write has committed
  assign csr_hold = exe_i.valid & (exe_i.instr_type == PRIV) &
                    ((s1_valid & s1_csr_we) | (s2_valid & s2_rec.csr_we));

  // no transfer on a flush edge, the op stays with the issue side
  assign ready_o     = s1_ready & ~csr_hold & ~flush_i;
  assign csr_raddr_o = exe_i.imm[CSR_ADDR_W-1:0];

  // ==============================
  // stage1
  // ==============================
  assign s1_ready = s2_ready | ~s1_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= exe_i.valid & ready_o;
    end
  end

  // operands plus CSR data and counters sampled at acceptance
  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_exe       <= exe_i;
      s1_csr_rdata <= csr_rdata_i;
      s1_timer_64  <= timer_64_i;
      s1_timer_id  <= timer_id_i;
    end
  end

  assign s1_csr_we = (s1_exe.instr_type == PRIV) &
                     ((s1_exe.priv_op == CSRWR) | (s1_exe.priv_op == CSRXCHG));

  // xchg replaces only the bits selected by src1
  assign s1_csr_wdata = (s1_exe.priv_op == CSRXCHG) ?
                        ((s1_csr_rdata & ~s1_exe.src1) | (s1_exe.src0 & s1_exe.src1)) :
                        s1_exe.src0;

  always_comb begin
    s1_wdata = '0;
    case (s1_exe.instr_type)
      BR:   s1_wdata = s1_exe.pc + XLEN'(4);
      PRIV: s1_wdata = s1_csr_rdata;
      MISC: begin
        case (s1_exe.misc_op)
          RDCNTVL: s1_wdata = s1_timer_64[31:0];
          RDCNTVH: s1_wdata = s1_timer_64[63:32];
          RDCNTID: s1_wdata = s1_timer_id;
          default: s1_wdata = '0;
        endcase
      end
      default: s1_wdata = '0;
    endcase
  end

  branch_unit u_branch_unit (
    .valid_i     (s1_valid & (s1_exe.instr_type == BR)),
    .signed_i    (s1_exe.signed_op),
    .branch_op_i (s1_exe.branch_op),
    .pc_i        (s1_exe.pc),
    .npc_i       (s1_exe.npc),
    .imm_i       (s1_exe.imm),
    .src0_i      (s1_exe.src0),
    .src1_i      (s1_exe.src1),
    .taken_o     (br_taken),
    .target_o    (br_target),
    .redirect_o  (br_redirect)
  );

  always_comb begin
    s1_wb             = '0;
    s1_wb.valid       = s1_valid;
    s1_wb.we          = s1_exe.pdest_valid;
    s1_wb.wdata       = s1_wdata;
    s1_wb.pdest       = s1_exe.pdest;
    s1_wb.rob_idx     = s1_exe.rob_idx;
    s1_wb.instr_type  = s1_exe.instr_type;
    s1_wb.csr_we      = s1_csr_we;
    s1_wb.csr_waddr   = s1_exe.imm[CSR_ADDR_W-1:0];
    s1_wb.csr_wdata   = s1_csr_wdata;
    s1_wb.br_taken    = br_taken;
    s1_wb.br_redirect = br_redirect;
    s1_wb.br_target   = br_target;
  end

  // ==============================
  // stage2
  // ==============================
  assign s2_ready = ~s2_valid | wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (flush_i) begin
      s2_valid <= 1'b0;
    end else if (s2_ready) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready) begin
      s2_rec <= s1_wb;
    end
  end

  always_comb begin
    wb_o       = s2_rec;
    wb_o.valid = s2_valid;
  end

endmodule

`default_nettype wire

// ==== misc_pkg.sv ====
/*
 * shared widths, opcode encodings, CSR numbers and the issue and commit records
 * of the miscellaneous pipe; imported by every RTL block and the testbench
 */
`default_nettype none

package misc_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int XLEN       = 32;
  localparam int ROB_IDX_W  = 6;
  localparam int PREG_W     = 7;
  localparam int CSR_ADDR_W = 14;

  // ==============================
  // opcode classes
  // ==============================
  typedef enum logic [1:0] {
    BR   = 2'd0,
    PRIV = 2'd1,
    MISC = 2'd2
  } instr_type_e;

  // signed_op selects signed or unsigned compare for BLT/BGE
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd2,
    BGE  = 3'd3,
    B    = 3'd4,
    JIRL = 3'd5
  } branch_op_e;

  typedef enum logic [1:0] {
    CSRRD   = 2'd0,
    CSRWR   = 2'd1,
    CSRXCHG = 2'd2
  } priv_op_e;

  typedef enum logic [1:0] {
    RDCNTVL = 2'd0,
    RDCNTVH = 2'd1,
    RDCNTID = 2'd2
  } misc_op_e;

  // ==============================
  // CSR numbers
  // ==============================
  localparam logic [CSR_ADDR_W-1:0] CSR_CRMD  = 14'h0000;
  localparam logic [CSR_ADDR_W-1:0] CSR_PRMD  = 14'h0001;
  localparam logic [CSR_ADDR_W-1:0] CSR_ERA   = 14'h0006;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0 = 14'h0030;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE1 = 14'h0031;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE2 = 14'h0032;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE3 = 14'h0033;
  localparam logic [CSR_ADDR_W-1:0] CSR_TID   = 14'h0040;

  // ==============================
  // pipe records
  // ==============================
  // issued micro-op, CSR number travels in imm
  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      npc;
    logic [XLEN-1:0]      src0;
    logic [XLEN-1:0]      src1;
    logic [XLEN-1:0]      imm;
    logic [PREG_W-1:0]    pdest;
    logic                 pdest_valid;
    logic [ROB_IDX_W-1:0] rob_idx;
    instr_type_e          instr_type;
    branch_op_e           branch_op;
    logic                 signed_op;
    priv_op_e             priv_op;
    misc_op_e             misc_op;
  } misc_exe_t;

  // writeback and commit record
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [XLEN-1:0]       wdata;
    logic [PREG_W-1:0]     pdest;
    logic [ROB_IDX_W-1:0]  rob_idx;
    instr_type_e           instr_type;
    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [XLEN-1:0]       csr_wdata;
    logic                  br_taken;
    logic                  br_redirect;
    logic [XLEN-1:0]       br_target;
  } misc_wb_t;

endpackage

`default_nettype wire

// ==== misc_subsystem.sv ====
/*
 * top of the misc execution block: the pipe plus its CSR file,
 * with CSR writes applied when the commit record is accepted
 */
`timescale 1ns/1ps
`default_nettype none

module misc_subsystem import misc_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      flush_i,
  input  wire misc_exe_t exe_i,
  output logic           ready_o,
  output misc_wb_t       wb_o,
  input  wire logic      wb_ready_i
);

  logic [CSR_ADDR_W-1:0] csr_raddr;
  logic [XLEN-1:0]       csr_rdata;
  logic [63:0]           timer_64;
  logic [XLEN-1:0]       timer_id;
  logic                  csr_commit_we;

  // a record handed over on a flush edge is dropped
  assign csr_commit_we = wb_o.valid & wb_ready_i & wb_o.csr_we & ~flush_i;

  misc_pipe u_misc_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .exe_i       (exe_i),
    .ready_o     (ready_o),
    .csr_raddr_o (csr_raddr),
    .csr_rdata_i (csr_rdata),
    .timer_64_i  (timer_64),
    .timer_id_i  (timer_id),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
  );

  csr_file u_csr_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .raddr_i     (csr_raddr),
    .commit_we_i (csr_commit_we),
    .waddr_i     (wb_o.csr_waddr),
    .wdata_i     (wb_o.csr_wdata),
    .rdata_o     (csr_rdata),
    .timer_64_o  (timer_64),
    .timer_id_o  (timer_id)
  );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
/*
 * commit-side checker that pops the expected queue on each accepted record,
 * compares every field and checks the stable-counter reads for monotonic order
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import misc_pkg::*; (
  input wire logic     clk,
  input wire logic     rst_n,
  input wire logic     flush_i,
  input wire logic     ready_i,
  input wire logic     wb_ready_i,
  input wire misc_wb_t wb_i
);

  misc_wb_t        exp_q [$];
  int              mode_q [$];
  string           test_name = "none";
  int              errors = 0;
  int              commits = 0;
  logic [XLEN-1:0] last_vl = '0;
  logic [XLEN-1:0] last_vh = '0;
  logic            vl_seen = 1'b0;
  logic            reset_checked = 1'b0;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic push_expected(input misc_wb_t rec, input int mode);
    exp_q.push_back(rec);
    mode_q.push_back(mode);
  endtask

  task automatic drop_pending();
    exp_q.delete();
    mode_q.delete();
  endtask

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  task automatic check_field(input string field, input logic [31:0] e, input logic [31:0] a);
    if (e !== a) begin
      $display("MISMATCH test=%s field=%s expected=%h actual=%h", test_name, field, e, a);
      errors++;
    end
  endtask

  // ==============================
  // reset state
  // ==============================
  always @(negedge clk) begin
    if (rst_n && !reset_checked) begin
      reset_checked = 1'b1;
      if (ready_i !== 1'b1 || wb_i.valid !== 1'b0) begin
        $display("after reset ready_o is not high or wb_o.valid is not low");
        errors++;
      end
    end
  end

  // ==============================
  // commit compare
  // ==============================
  always @(negedge clk) begin
    misc_wb_t e;
    int       mode;
    if (rst_n && wb_i.valid && wb_ready_i && !flush_i) begin
      commits++;
      if (exp_q.size() == 0) begin
        $display("test=%s commit of rob_idx %0d with no op pending", test_name, wb_i.rob_idx);
        errors++;
      end else begin
        e    = exp_q.pop_front();
        mode = mode_q.pop_front();
        check_field("rob_idx", 32'(e.rob_idx), 32'(wb_i.rob_idx));
        check_field("instr_type", 32'(e.instr_type), 32'(wb_i.instr_type));
        check_field("we", 32'(e.we), 32'(wb_i.we));
        check_field("pdest", 32'(e.pdest), 32'(wb_i.pdest));
        check_field("csr_we", 32'(e.csr_we), 32'(wb_i.csr_we));
        check_field("br_taken", 32'(e.br_taken), 32'(wb_i.br_taken));
        check_field("br_redirect", 32'(e.br_redirect), 32'(wb_i.br_redirect));
        check_field("br_target", e.br_target, wb_i.br_target);
        check_field("wdata", e.wdata, wb_i.wdata);
        if (e.csr_we) begin
          check_field("csr_waddr", 32'(e.csr_waddr), 32'(wb_i.csr_waddr));
          check_field("csr_wdata", e.csr_wdata, wb_i.csr_wdata);
        end
        if (mode == 1) begin
          // low word must strictly increase between reads
          if (vl_seen && wb_i.wdata <= last_vl) begin
            $display("MISMATCH test=%s field=cntvl expected=above %h actual=%h",
                     test_name, last_vl, wb_i.wdata);
            errors++;
          end
          last_vl = wb_i.wdata;
          vl_seen = 1'b1;
        end else if (mode == 2) begin
          if (wb_i.wdata < last_vh) begin
            $display("MISMATCH test=%s field=cntvh expected=at least %h actual=%h",
                     test_name, last_vh, wb_i.wdata);
            errors++;
          end
          last_vh = wb_i.wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_misc.sv ====
/*
 * testbench top for the misc subsystem with clock, reset, seeded random ops,
 * a CSR and counter mirror model feeding the checker, and the cycle-limit timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_misc import misc_pkg::*; ();

  localparam int N_RESET = 8;
  localparam int N_BR    = 150;
  localparam int N_CSR   = 150;
  localparam int N_CNT   = 80;
  localparam int N_ORDER = 120;
  localparam int N_FLUSH = 120;
  localparam int N_TOTAL = N_RESET + N_BR + N_CSR + N_CNT + N_ORDER + N_FLUSH;
  localparam int TIMEOUT = N_TOTAL * 8 + 100;

  typedef struct packed {
    logic                  we;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } csr_upd_t;

  logic      clk;
  logic      rst_n;
  logic      flush_i;
  logic      wb_ready_i;
  misc_exe_t exe;
  logic      ready;
  misc_wb_t  wb;

  logic [XLEN-1:0]      csr_mirror [8];
  logic [63:0]          cnt_mirror;
  csr_upd_t             upd_q [$];
  logic                 bp_en;
  logic                 flush_en;
  logic [ROB_IDX_W-1:0] rob;
  int                   cycles;
  int                   accepted;
  int                   dropped;

  misc_subsystem misc_subsystem_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe),
    .ready_o    (ready),
    .wb_o       (wb),
    .wb_ready_i (wb_ready_i)
  );

  tb_checker u_tb_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .ready_i    (ready),
    .wb_ready_i (wb_ready_i),
    .wb_i       (wb)
  );

  always #10 clk = ~clk;

  // ==============================
  // reference model
  // ==============================
  function automatic int csr_slot(input logic [CSR_ADDR_W-1:0] a);
    case (a)
      CSR_CRMD:  return 0;
      CSR_PRMD:  return 1;
      CSR_ERA:   return 2;
      CSR_SAVE0: return 3;
      CSR_SAVE1: return 4;
      CSR_SAVE2: return 5;
      CSR_SAVE3: return 6;
      CSR_TID:   return 7;
      default:   return -1;
    endcase
  endfunction

  function automatic logic [CSR_ADDR_W-1:0] csr_num(input int i);
    case (i)
      0:       return CSR_CRMD;
      1:       return CSR_PRMD;
      2:       return CSR_ERA;
      3:       return CSR_SAVE0;
      4:       return CSR_SAVE1;
      5:       return CSR_SAVE2;
      6:       return CSR_SAVE3;
      default: return CSR_TID;
    endcase
  endfunction

  function automatic misc_wb_t expect_record(input misc_exe_t op);
    misc_wb_t        r;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] tgt;
    logic [XLEN-1:0] nxt;
    logic            eq;
    logic            lt;
    logic            cond;
    int              slot;
    r            = '0;
    r.valid      = 1'b1;
    r.we         = op.pdest_valid;
    r.pdest      = op.pdest;
    r.rob_idx    = op.rob_idx;
    r.instr_type = op.instr_type;
    if (op.instr_type == BR) begin
      eq = (op.src0 == op.src1);
      lt = op.signed_op ? ($signed(op.src0) < $signed(op.src1)) : (op.src0 < op.src1);
      case (op.branch_op)
        BEQ:     cond = eq;
        BNE:     cond = !eq;
        BLT:     cond = lt;
        BGE:     cond = !lt;
        default: cond = 1'b1;
      endcase
      tgt           = ((op.branch_op == JIRL) ? op.src0 : op.pc) + op.imm;
      nxt           = cond ? tgt : op.pc + 32'd4;
      r.wdata       = op.pc + 32'd4;
      r.br_taken    = cond;
      r.br_target   = tgt;
      r.br_redirect = (nxt != op.npc);
    end else if (op.instr_type == PRIV) begin
      slot        = csr_slot(op.imm[CSR_ADDR_W-1:0]);
      old         = (slot >= 0) ? csr_mirror[slot] : '0;
      r.wdata     = old;
      r.csr_waddr = op.imm[CSR_ADDR_W-1:0];
      r.csr_we    = (op.priv_op != CSRRD);
      // xchg keeps old bits outside the src1 mask
      r.csr_wdata = (op.priv_op == CSRXCHG) ? ((old & ~op.src1) | (op.src0 & op.src1)) : op.src0;
    end else if (op.misc_op == RDCNTID) begin
      r.wdata = csr_mirror[7];
    end else if (op.misc_op == RDCNTVL) begin
      r.wdata = cnt_mirror[31:0];
    end else begin
      r.wdata = cnt_mirror[63:32];
    end
    return r;
  endfunction

  function automatic int wdata_mode(input misc_exe_t op);
    if (op.instr_type != MISC) return 0;
    if (op.misc_op == RDCNTVL) return 1;
    if (op.misc_op == RDCNTVH) return 2;
    return 0;
  endfunction

  // counter value that the DUT holds between two rising edges
  always @(posedge clk) begin
    if (!rst_n) begin
      cnt_mirror = '0;
    end else begin
      cnt_mirror = cnt_mirror + 64'd1;
    end
  end

  // sampled on the falling edge where inputs and state match the next rising edge
  always @(negedge clk) begin
    misc_wb_t rec;
    csr_upd_t u;
    logic     acc;
    int       slot;
    if (rst_n) begin
      acc = exe.valid & ready;
      // expectation uses the mirror before this edge's commit lands
      if (acc) rec = expect_record(exe);
      if (wb.valid && wb_ready_i && !flush_i && upd_q.size() > 0) begin
        u    = upd_q.pop_front();
        slot = csr_slot(u.addr);
        if (u.we && slot >= 0) csr_mirror[slot] = u.data;
      end
      if (flush_i) begin
        dropped += upd_q.size();
        upd_q.delete();
        u_tb_checker.drop_pending();
      end
      if (acc) begin
        upd_q.push_back({rec.csr_we, rec.csr_waddr, rec.csr_wdata});
        u_tb_checker.push_expected(rec, wdata_mode(exe));
        accepted++;
      end
    end
  end

  // ==============================
  // stimulus
  // ==============================
  always @(posedge clk) begin
    #1;
    wb_ready_i = bp_en ? (($urandom % 10) >= 3) : 1'b1;
    flush_i    = flush_en && (($urandom % 12) == 0);
  end

  function automatic misc_exe_t random_op(input instr_type_e t);
    misc_exe_t op;
    int        sel;
    op             = '0;
    op.valid       = 1'b1;
    op.instr_type  = t;
    op.pc          = $urandom & 32'hffff_fffc;
    op.src0        = $urandom;
    op.src1        = (($urandom % 4) == 0) ? op.src0 : $urandom;
    op.pdest       = PREG_W'($urandom % 128);
    op.pdest_valid = 1'($urandom % 2);
    op.signed_op   = 1'($urandom % 2);
    op.branch_op   = branch_op_e'(3'($urandom_range(0, 5)));
    op.priv_op     = priv_op_e'(2'($urandom_range(0, 2)));
    op.misc_op     = misc_op_e'(2'($urandom_range(0, 2)));
    if (t == BR) begin
      op.imm = (($urandom % 512) << 2) - 32'd1024;
      sel    = $urandom % 3;
      if (sel == 0) op.npc = op.pc + 32'd4;
      else if (sel == 1) op.npc = ((op.branch_op == JIRL) ? op.src0 : op.pc) + op.imm;
      else op.npc = $urandom;
    end else if (t == PRIV) begin
      // mostly implemented numbers plus a few unimplemented ones in 0x100..0x1ff
      if (($urandom % 5) != 0) op.imm = XLEN'(csr_num($urandom % 8));
      else op.imm = 32'h100 | ($urandom % 256);
    end else begin
      op.imm = $urandom;
    end
    op.rob_idx = rob;
    rob        = rob + 1'b1;
    return op;
  endfunction

  task automatic send_op(input misc_exe_t op);
    exe = op;
    forever begin
      @(negedge clk);
      if (ready) break;
    end
    @(posedge clk);
    #1;
    exe = '0;
    if (($urandom % 5) == 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_test(input string name, input int n, input int kind);
    misc_exe_t op;
    int        e0;
    int        c0;
    int        a0;
    int        t;
    e0 = u_tb_checker.errors;
    c0 = u_tb_checker.commits;
    a0 = accepted;
    u_tb_checker.set_test(name);
    bp_en    = (kind != 0);
    flush_en = (kind == 5);
    for (int i = 0; i < n; i++) begin
      case (kind)
        0: begin
          op          = random_op(PRIV);
          op.priv_op  = CSRRD;
          op.imm      = XLEN'(csr_num(i));
        end
        1: op = random_op(BR);
        2: op = random_op(PRIV);
        3: begin
          if (($urandom % 10) == 0) begin
            op         = random_op(PRIV);
            op.priv_op = CSRWR;
            op.imm     = XLEN'(CSR_TID);
          end else begin
            op = random_op(MISC);
          end
        end
        default: begin
          t  = $urandom % 3;
          op = random_op(instr_type_e'(2'(t)));
        end
      endcase
      send_op(op);
    end
    flush_en = 1'b0;
    while (u_tb_checker.pending_count() != 0) begin
      @(posedge clk);
      #1;
    end
    $display("[%s] accepted=%0d commits=%0d errors=%0d", name, accepted - a0,
             u_tb_checker.commits - c0, u_tb_checker.errors - e0);
  endtask

  // ==============================
  // timeout
  // ==============================
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, DUT stopped making progress", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h68ab_9c2e));
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush_i      = 1'b0;
    wb_ready_i   = 1'b1;
    exe          = '0;
    bp_en        = 1'b0;
    flush_en     = 1'b0;
    rob          = '0;
    cnt_mirror   = '0;
    cycles       = 0;
    accepted     = 0;
    dropped      = 0;
    for (int i = 0; i < 8; i++) csr_mirror[i] = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    run_test("reset_state", N_RESET, 0);
    run_test("branch", N_BR, 1);
    run_test("csr", N_CSR, 2);
    run_test("counter", N_CNT, 3);
    run_test("order", N_ORDER, 4);
    run_test("flush", N_FLUSH, 5);
    $display("tests=6 accepted=%0d commits=%0d dropped=%0d errors=%0d", accepted,
             u_tb_checker.commits, dropped, u_tb_checker.errors);
    if (u_tb_checker.errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
